/* test/mul_trace.txt */
// fields cmd_n_mulw_sign_mulcand_muler_hi_lo in hex, sign bit 0 mulcand, bit 1 muler
// cmd 0 op with stray mul_valid n cycles after accept (0 none), cmd 1 flush n cycles after accept
1_05_0_3_0000000000000003_0000000000000005_0000000000000000_0000000000000000
0_00_0_0_0000000000000003_0000000000000005_0000000000000000_000000000000000f
0_00_0_0_ffffffffffffffff_ffffffffffffffff_fffffffffffffffe_0000000000000001
0_00_0_3_ffffffffffffffff_ffffffffffffffff_0000000000000000_0000000000000001
0_00_0_1_ffffffffffffffff_ffffffffffffffff_ffffffffffffffff_0000000000000001
0_00_0_2_ffffffffffffffff_ffffffffffffffff_ffffffffffffffff_0000000000000001
0_00_0_3_8000000000000000_8000000000000000_4000000000000000_0000000000000000
0_00_0_3_8000000000000000_0000000000000001_ffffffffffffffff_8000000000000000
0_00_0_1_8000000000000000_ffffffffffffffff_8000000000000000_8000000000000000
0_00_0_2_ffffffffffffffff_8000000000000000_8000000000000000_8000000000000000
0_00_0_3_0000000000000000_8000000000000000_0000000000000000_0000000000000000
0_00_0_3_0000000000000007_fffffffffffffffd_ffffffffffffffff_ffffffffffffffeb
0_00_0_0_0000000100000000_0000000100000000_0000000000000001_0000000000000000
0_00_0_0_0000000000010001_0000000000010001_0000000000000000_0000000100020001
0_00_0_3_7fffffffffffffff_7fffffffffffffff_3fffffffffffffff_0000000000000001
0_00_0_3_7fffffffffffffff_8000000000000000_c000000000000000_8000000000000000
0_00_0_0_7fffffffffffffff_8000000000000000_3fffffffffffffff_8000000000000000
0_00_0_1_fffffffffffffffe_0000000000000003_ffffffffffffffff_fffffffffffffffa
0_00_0_2_0000000000000002_fffffffffffffffe_ffffffffffffffff_fffffffffffffffc
0_00_0_0_00000000deadbeef_0000000000000010_0000000000000000_0000000deadbeef0
0_00_0_3_ffffffffffff0000_0000000000010000_ffffffffffffffff_ffffffff00000000
0_00_0_0_5555555555555555_0000000000000003_0000000000000000_ffffffffffffffff
0_00_0_0_aaaaaaaaaaaaaaaa_0000000000000002_0000000000000001_5555555555555554
0_00_0_3_aaaaaaaaaaaaaaaa_0000000000000002_ffffffffffffffff_5555555555555554
0_00_0_0_0000000000000003_aaaaaaaaaaaaaaaa_0000000000000001_fffffffffffffffe
0_00_0_3_0000000000000003_aaaaaaaaaaaaaaaa_fffffffffffffffe_fffffffffffffffe
0_00_1_0_0000000000000003_0000000000000005_0000000000000000_000000000000000f
0_00_1_3_00000000ffffffff_00000000ffffffff_0000000000000000_0000000000000001
0_00_1_0_0000000080000000_0000000000000001_0000000000000000_ffffffff80000000
0_00_1_3_123456789abcdef0_fedcba9800000001_0000000000000000_ffffffff9abcdef0
0_00_1_3_0000000000000007_00000000fffffffd_0000000000000000_ffffffffffffffeb
0_00_1_3_000000007fffffff_0000000000000002_0000000000000000_fffffffffffffffe
0_00_1_0_0000000000010001_0000000000010001_0000000000000000_0000000000020001
1_10_0_3_7fffffffffffffff_7fffffffffffffff_0000000000000000_0000000000020001
1_12_1_0_0000000000000003_0000000000000005_0000000000000000_0000000000020001
0_00_0_2_0000000000000002_fffffffffffffffe_ffffffffffffffff_fffffffffffffffc
1_22_0_0_ffffffffffffffff_ffffffffffffffff_ffffffffffffffff_fffffffffffffffc
0_05_0_0_ffffffffffffffff_ffffffffffffffff_fffffffffffffffe_0000000000000001
0_22_0_3_8000000000000000_0000000000000001_ffffffffffffffff_8000000000000000
0_03_1_3_0000000000000007_00000000fffffffd_0000000000000000_ffffffffffffffeb
0_12_1_0_0000000080000000_0000000000000001_0000000000000000_ffffffff80000000

/* compile.f */
+incdir+include
logic/mul_data_pkg.sv
logic/mul_ctrl_pkg.sv
logic/mul_step_if.sv
logic/operand_prep.sv
logic/booth_select.sv
logic/product_accum.sv
logic/mul_ctrl.sv
logic/booth_mul_top.sv
test/tb_booth_mul.sv

/* Bender.yml */
package:
  name: booth_mul

export_include_dirs:
  - include

sources:
  - files:
      - logic/mul_data_pkg.sv
      - logic/mul_ctrl_pkg.sv
      - logic/mul_step_if.sv
      - logic/operand_prep.sv
      - logic/booth_select.sv
      - logic/product_accum.sv
      - logic/mul_ctrl.sv
      - logic/booth_mul_top.sv
  - target: test
    files:
      - test/tb_booth_mul.sv

/* test/tb_booth_mul.sv */
`timescale 1ns/100ps

module tb_booth_mul;

	// ******************************
	// dut signals
	// ******************************

	logic clk;
	logic rst;
	logic mul_valid;
	logic flush;
	logic mulw;
	logic [1:0] mul_signed;
	logic [63:0] mulcand;
	logic [63:0] muler;
	logic mul_ready;
	logic out_valid;
	logic [63:0] result_hi;
	logic [63:0] result_lo;

	// trace entries with the first field in the msb
	// cmd 4, n 8, mulw 4, sign 4, mulcand, muler, hi, lo
	logic [275:0] trace_mem [0:63];
	int n_ops = 0;

	// fields of the entry being run
	logic [3:0] cur_cmd;
	int cur_n;
	logic cur_mulw;
	logic [1:0] cur_sign;
	logic [63:0] cur_a;
	logic [63:0] cur_b;
	logic [63:0] cur_hi;
	logic [63:0] cur_lo;

	// result the dut should still be holding
	logic [63:0] prev_hi;
	logic [63:0] prev_lo;

	booth_mul_top i_booth_mul_top (
		.clk(clk),
		.rst(rst),
		.mul_valid(mul_valid),
		.flush(flush),
		.mulw(mulw),
		.mul_signed(mul_signed),
		.mulcand(mulcand),
		.muler(muler),
		.mul_ready(mul_ready),
		.out_valid(out_valid),
		.result_hi(result_hi),
		.result_lo(result_lo)
	);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ******************************
	// reporting
	// ******************************

	task automatic abort_run;
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_error(input string what);
		$display("ERROR at %0t: %s", $time, what);
		abort_run();
	endtask

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	// ******************************
	// driver and checker
	// ******************************

	// outputs settled and inputs free to change
	task automatic next_cycle;
		@(posedge clk);
		#1;
	endtask

	task automatic present_op;
		mulw = cur_mulw;
		mul_signed = cur_sign;
		mulcand = cur_a;
		muler = cur_b;
		mul_valid = 1'b1;
	endtask

	// between accept and result
	task automatic check_busy;
		check_val("out_valid", out_valid, 0);
		check_val("mul_ready", mul_ready, 0);
		check_val("result_hi", result_hi, prev_hi);
		check_val("result_lo", result_lo, prev_lo);
	endtask

	task automatic run_op;
		int lat;
		int k;
		logic seen;
		lat = cur_mulw ? 19 : 35;
		k = 0;
		seen = 1'b0;
		check_val("mul_ready", mul_ready, 1);
		present_op();
		next_cycle();
		// accept edge passed
		mul_valid = 1'b0;
		while (!seen && k < lat + 4) begin
			next_cycle();
			k++;
			if (out_valid) begin
				seen = 1'b1;
			end else begin
				check_busy();
				// stray request that the busy unit ignores
				mul_valid = (k == cur_n);
				if (k == cur_n) begin
					mulw = ~cur_mulw;
					mul_signed = ~cur_sign;
					mulcand = ~cur_a;
					muler = ~cur_b;
				end
			end
		end
		mul_valid = 1'b0;
		assert (seen) else begin
			report_error($sformatf("no out_valid within %0d cycles of accept", lat + 4));
		end
		check_val("out_valid latency", k, lat);
		check_val("mul_ready", mul_ready, 0);
		check_val("result_hi", result_hi, cur_hi);
		check_val("result_lo", result_lo, cur_lo);
		prev_hi = cur_hi;
		prev_lo = cur_lo;
		// one cycle pulse, ready again, result held
		next_cycle();
		check_val("out_valid", out_valid, 0);
		check_val("mul_ready", mul_ready, 1);
		check_val("result_hi", result_hi, prev_hi);
		check_val("result_lo", result_lo, prev_lo);
	endtask

	task automatic run_flush;
		int k;
		k = 0;
		check_val("mul_ready", mul_ready, 1);
		present_op();
		next_cycle();
		mul_valid = 1'b0;
		while (k < cur_n) begin
			next_cycle();
			k++;
			check_busy();
		end
		flush = 1'b1;
		next_cycle();
		flush = 1'b0;
		// idle again, old result kept
		check_val("out_valid", out_valid, 0);
		check_val("mul_ready", mul_ready, 1);
		check_val("result_hi", result_hi, cur_hi);
		check_val("result_lo", result_lo, cur_lo);
		prev_hi = cur_hi;
		prev_lo = cur_lo;
	endtask

	// entries stop at the first unloaded word
	function automatic int count_entries;
		int i;
		i = 0;
		while (i < 64 && ((^trace_mem[i]) !== 1'bx)) begin
			i++;
		end
		return i;
	endfunction

	// ******************************
	// main sequence
	// ******************************

	initial begin
		int i;
		$timeformat(-9, 1, " ns", 0);
		rst = 1'b1;
		mul_valid = 1'b0;
		flush = 1'b0;
		mulw = 1'b0;
		mul_signed = 2'b00;
		mulcand = '0;
		muler = '0;
		prev_hi = '0;
		prev_lo = '0;
		$readmemh("test/mul_trace.txt", trace_mem);
		n_ops = count_entries();
		if (n_ops == 0) begin
			report_error("trace file test/mul_trace.txt holds no operations");
		end
		repeat (5) @(posedge clk);
		#1;
		// values right out of reset
		check_val("mul_ready", mul_ready, 1);
		check_val("out_valid", out_valid, 0);
		check_val("result_hi", result_hi, 0);
		check_val("result_lo", result_lo, 0);
		rst = 1'b0;
		for (i = 0; i < n_ops; i++) begin
			cur_cmd = trace_mem[i][275:272];
			cur_n = trace_mem[i][271:264];
			cur_mulw = trace_mem[i][260];
			cur_sign = trace_mem[i][257:256];
			cur_a = trace_mem[i][255:192];
			cur_b = trace_mem[i][191:128];
			cur_hi = trace_mem[i][127:64];
			cur_lo = trace_mem[i][63:0];
			case (cur_cmd)
				4'h0: run_op();
				4'h1: run_flush();
				default: report_error($sformatf("unknown command in trace entry %0d", i));
			endcase
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

	// 40 cycles per trace entry
	initial begin
		wait (n_ops != 0);
		#(n_ops * 40 * 8);
		report_error("watchdog expired before the trace was finished");
	end

endmodule

/* logic/booth_mul_top.sv */
`timescale 1ns/100ps

module booth_mul_top import mul_data_pkg::*; import mul_ctrl_pkg::*; (
	input logic clk,
	input logic rst,
	input logic mul_valid,
	input logic flush,
	input logic mulw,
	input sign_mode_t mul_signed,
	input xlen_t mulcand,
	input xlen_t muler,
	output logic mul_ready,
	output logic out_valid,
	output xlen_t result_hi,
	output xlen_t result_lo
);

	// strobes from the controller
	mul_step_if step_bus ();

	// datapath wires
	ext_t mcand_ext;
	logic [2:0] booth_bits;
	pp_t pp;

	// ******************************
	// control
	// ******************************

	mul_ctrl i_mul_ctrl (
		.clk(clk),
		.rst(rst),
		.mul_valid(mul_valid),
		.flush(flush),
		.mulw(mulw),
		.mul_ready(mul_ready),
		.out_valid(out_valid),
		.step_bus(step_bus)
	);

	// ******************************
	// datapath
	// ******************************

	operand_prep i_operand_prep (
		.clk(clk),
		.rst(rst),
		.step_bus(step_bus),
		.mulcand(mulcand),
		.muler(muler),
		.mul_signed(mul_signed),
		.mcand_ext(mcand_ext),
		.booth_bits(booth_bits)
	);

	booth_select i_booth_select (
		.mcand_ext(mcand_ext),
		.booth_bits(booth_bits),
		.pp(pp)
	);

	product_accum i_product_accum (
		.clk(clk),
		.rst(rst),
		.step_bus(step_bus),
		.pp(pp),
		.result_hi(result_hi),
		.result_lo(result_lo)
	);

endmodule

/* logic/mul_ctrl.sv */
`timescale 1ns/100ps

`include "booth_mul_macros.svh"

module mul_ctrl import mul_ctrl_pkg::*; (
	input logic clk,
	input logic rst,
	input logic mul_valid,
	input logic flush,
	input logic mulw,
	output logic mul_ready,
	output logic out_valid,
	mul_step_if.ctrl step_bus
);

	mul_state_t state;

	// steps still to issue
	step_cnt_t cnt;

	// registered step strobe, one cycle behind the count
	logic step_r;

	// mode of the running operation
	logic word_q;

	// new operation taken this cycle
	logic accept;

	assign accept = (state == idle) && mul_valid;

	// ******************************
	// fsm and step counter
	// ******************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			cnt <= '0;
			step_r <= 1'b0;
			word_q <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (accept) begin
						state <= busy;
						cnt <= mulw ? step_cnt_t'(`STEPS_W) : step_cnt_t'(`STEPS_D);
						word_q <= mulw;
					end
				end
				busy: begin
					if (flush) begin
						// abandon the operation
						state <= idle;
						cnt <= '0;
						step_r <= 1'b0;
					end else if (cnt != '0) begin
						cnt <= cnt - 1'b1;
						step_r <= 1'b1;
					end else begin
						step_r <= 1'b0;
						// leave once the last step has drained
						if (!step_r) begin
							state <= done;
						end
					end
				end
				done: state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// ******************************
	// outputs
	// ******************************

	assign mul_ready = (state == idle);
	assign out_valid = (state == done);

	// datapath strobes
	assign step_bus.load = accept;
	// flush also blocks the result write
	assign step_bus.clear = accept || (flush && state != idle);
	assign step_bus.step = step_r && !flush;
	// mode follows mulw until accepted
	assign step_bus.word = (state == idle) ? mulw : word_q;

	// ready is only given back after the result cycle
	ready_valid_excl_a: assert property (@(posedge clk) disable iff (rst)
		!(mul_ready && out_valid));

	// single cycle result pulse
	valid_pulse_a: assert property (@(posedge clk) disable iff (rst)
		out_valid |=> !out_valid);

	// counter holds at zero until the next accept
	cnt_no_wrap_a: assert property (@(posedge clk) disable iff (rst)
		(state != idle && cnt == '0) |=> (cnt == '0));

endmodule

/* logic/product_accum.sv */
`timescale 1ns/100ps

`include "booth_mul_macros.svh"

module product_accum import mul_data_pkg::*; (
	input logic clk,
	input logic rst,
	mul_step_if.dp step_bus,
	input pp_t pp,
	output xlen_t result_hi,
	output xlen_t result_lo
);

	// running sum
	acc_t acc;

	// arithmetic shift of the old sum
	acc_t acc_sh;

	// sum after this step
	acc_t acc_next;

	// step seen in the previous cycle
	logic step_d;

	// product view of the accumulator
	prod_t prod;

	// low word of a mulw product
	logic [`WLEN-1:0] word_lo;

	// ******************************
	// shift and add
	// ******************************

	// shift first, then add at a fixed offset
	// after the last step the 64-bit product sits at bit 0
	assign acc_sh = acc_t'($signed(acc) >>> 2);
	assign acc_next = acc_sh + {pp[`EXT_W], pp, {`XLEN{1'b0}}};

	always_ff @(posedge clk) begin
		if (step_bus.clear) begin
			acc <= '0;
		end else if (step_bus.step) begin
			acc <= acc_next;
		end
	end

	// ******************************
	// result formatting
	// ******************************

	assign prod = acc[2*`XLEN-1:0];

	// word mode runs fewer steps
	// so its product ends up XLEN-WLEN bits higher
	assign word_lo = acc[`XLEN-1 -: `WLEN];

	// results latch on the cycle after the last step
	// clear in that cycle means the operation was flushed
	always_ff @(posedge clk) begin
		if (rst) begin
			step_d <= 1'b0;
			result_hi <= '0;
			result_lo <= '0;
		end else begin
			step_d <= step_bus.step;
			if (step_d && !step_bus.step && !step_bus.clear) begin
				if (step_bus.word) begin
					// mulw gives the sign extended low word
					result_hi <= '0;
					result_lo <= {{(`XLEN - `WLEN){word_lo[`WLEN-1]}}, word_lo};
				end else begin
					result_hi <= prod[2*`XLEN-1:`XLEN];
					result_lo <= prod[`XLEN-1:0];
				end
			end
		end
	end

endmodule

/* logic/booth_select.sv */
`timescale 1ns/100ps

`include "booth_mul_macros.svh"

module booth_select import mul_data_pkg::*; (
	input ext_t mcand_ext,
	input logic [2:0] booth_bits,
	output pp_t pp
);

	// digit decode
	logic one;
	logic two;
	logic neg;

	// magnitude before the sign is applied
	pp_t mag;

	// ******************************
	// radix-4 recoding
	// ******************************

	// 001 010 101 110 give magnitude one
	assign one = booth_bits[1] ^ booth_bits[0];

	// 011 and 100 give magnitude two
	assign two = (booth_bits == 3'b011) || (booth_bits == 3'b100);

	// upper bit set means negative
	// 111 negates a zero magnitude
	assign neg = booth_bits[2];

	// ******************************
	// partial product
	// ******************************

	always_comb begin
		mag = '0;
		if (one) begin
			// sign extend by one bit
			mag = {mcand_ext[`EXT_W-1], mcand_ext};
		end else if (two) begin
			// x2 by shifting left
			mag = {mcand_ext, 1'b0};
		end
	end

	// two's complement negate
	// the +1 is folded into this sum so the accumulator needs no carry in
	assign pp = (neg ? ~mag : mag) + pp_t'(neg);

	// zero digits must leave the accumulator untouched
	// 111 relies on the negate wrapping to zero
	always_comb begin
		if (booth_bits == 3'b000 || booth_bits == 3'b111) begin
			zero_digit_a: assert final (pp == '0);
		end
	end

endmodule

/* logic/operand_prep.sv */
`timescale 1ns/100ps

`include "booth_mul_macros.svh"

module operand_prep import mul_data_pkg::*; import mul_ctrl_pkg::*; (
	input logic clk,
	input logic rst,
	mul_step_if.dp step_bus,
	input xlen_t mulcand,
	input xlen_t muler,
	input sign_mode_t mul_signed,
	output ext_t mcand_ext,
	output logic [2:0] booth_bits
);

	// registered multiplicand, stable for the whole operation
	ext_t mcand_q;

	// multiplier with a zero appended below bit 0
	// the low three bits form the current booth group
	logic [`EXT_W:0] mul_sr;

	// ******************************
	// operand extension
	// ******************************

	// word mode looks only at the low word
	// sign bit copied up when that operand is signed
	function automatic ext_t extend(input xlen_t v, input logic word, input logic sgn);
		ext_t r;
		if (word) begin
			r = {{(`EXT_W - `WLEN){sgn & v[`WLEN-1]}}, v[`WLEN-1:0]};
		end else begin
			r = {{(`EXT_W - `XLEN){sgn & v[`XLEN-1]}}, v};
		end
		return r;
	endfunction

	// ******************************
	// registers
	// ******************************

	// multiplicand captured at accept
	always_ff @(posedge clk) begin
		if (step_bus.load) begin
			mcand_q <= extend(mulcand, step_bus.word, mul_signed[0]);
		end
	end

	// multiplier shift register
	// cleared on reset so the first group decodes as a zero digit
	always_ff @(posedge clk) begin
		if (rst) begin
			mul_sr <= '0;
		end else if (step_bus.load) begin
			mul_sr <= {extend(muler, step_bus.word, mul_signed[1]), 1'b0};
		end else if (step_bus.step) begin
			// next overlapping group of three
			mul_sr <= mul_sr >> 2;
		end
	end

	assign mcand_ext = mcand_q;
	assign booth_bits = mul_sr[2:0];

endmodule

/* logic/mul_step_if.sv */
`timescale 1ns/100ps

// strobes from the controller to the datapath
interface mul_step_if;

	// latch operands on the next edge
	logic load;

	// one booth step on the next edge
	logic step;

	// zero the accumulator
	// also used to cancel a pending result on flush
	logic clear;

	// word mode of the running operation
	logic word;

	// ******************************
	// views
	// ******************************

	// controller side
	modport ctrl (
		output load,
		output step,
		output clear,
		output word
	);

	// datapath side
	modport dp (
		input load,
		input step,
		input clear,
		input word
	);

endinterface

/* logic/mul_ctrl_pkg.sv */
`include "booth_mul_macros.svh"

package mul_ctrl_pkg;

	// controller states
	// busy covers the steps and the two drain cycles
	typedef enum logic [1:0] {
		idle = 2'b00,
		busy = 2'b01,
		done = 2'b10
	} mul_state_t;

	// bit 0 set for a signed multiplicand
	// bit 1 set for a signed multiplier
	typedef logic [1:0] sign_mode_t;

	// remaining radix-4 steps
	typedef logic [`CNT_W-1:0] step_cnt_t;

endpackage

/* logic/mul_data_pkg.sv */
`include "booth_mul_macros.svh"

package mul_data_pkg;

	// ******************************
	// datapath vectors
	// ******************************

	// one register operand or one result half
	typedef logic [`XLEN-1:0] xlen_t;

	// operand after extension
	// full operand plus two bits, or low word plus thirty four
	typedef logic [`EXT_W-1:0] ext_t;

	// partial product
	// one bit more than the operand for the x2 digit
	typedef logic [`EXT_W:0] pp_t;

	// shift-add accumulator
	// top part takes the partial product, bottom part collects shifted bits
	typedef logic [2*`EXT_W-1:0] acc_t;

	// full product as seen by the result halves
	typedef logic [2*`XLEN-1:0] prod_t;

endpackage

/* include/booth_mul_macros.svh */
`ifndef BOOTH_MUL_MACROS_SVH
`define BOOTH_MUL_MACROS_SVH

// ******************************
// widths fixed by the isa
// ******************************

// register width of the core
`define XLEN 64
// low word used by mulw
`define WLEN 32

// operand after sign or zero extension
// two extra bits keep the radix-4 step count whole
`define EXT_W 66

// ******************************
// iteration counts
// ******************************

// radix-4 steps, one per two extended bits
`define STEPS_D 33
`define STEPS_W 17
// wide enough for STEPS_D
`define CNT_W 6

`endif
